// File: cpuPkg.sv
package cpuPkg;

    // ########################################
    // Stage constants
    // ########################################
    localparam int MEM_TIMEOUT = 16;             // Wait cycles before bus error
    localparam int TIMER_WIDTH = 5;              // Wide enough for MEM_TIMEOUT

    // ########################################
    // Load and store kinds
    // ########################################
    typedef enum logic [2:0] {
        LD_NONE,
        LD_LB,
        LD_LBU,
        LD_LH,
        LD_LHU,
        LD_LW
    } loadType_t;

    typedef enum logic [1:0] {
        ST_NONE,
        ST_SB,
        ST_SH,
        ST_SW
    } storeType_t;

    // ########################################
    // Exception flags and stage bundles
    // ########################################
    typedef struct packed {
        logic [7:0]  upstream;                   // Flags raised by IF/ID/EXE
        logic        adEL;                       // Load address error
        logic        adES;                       // Store address error
        logic        busErr;                     // Memory did not answer
    } exceptType_t;

    typedef struct packed {
        logic [31:0] aluOut;                     // Address or ALU result
        logic [31:0] storeData;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        isBranch;
        logic        isImmeJump;
        loadType_t   loadType;
        storeType_t  storeType;
        logic [4:0]  dst;
        logic        regsWr;
        logic [1:0]  wbSel;
        exceptType_t except;
        logic [31:0] hi;
        logic [31:0] lo;
        logic        valid;                      // Zero marks a bubble
    } exeMemBundle_t;

    typedef struct packed {
        logic [31:0] result;                     // Load data or aluOut
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  dst;
        logic        regsWr;
        logic [1:0]  wbSel;
        exceptType_t except;
        logic [31:0] hi;
        logic [31:0] lo;
    } memWbBundle_t;

    // Read word, lane 0 sits at address offset 0
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } dataWord_u;

endpackage

// File: memStageReg.sv
`timescale 1ns/1ps

module memStageReg import cpuPkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  logic          flush,
    input  logic          wrEn,                  // Low while the stage stalls
    input  exeMemBundle_t exeIn,
    output exeMemBundle_t memOut
);

    // ########################################
    // EXE/MEM register
    // ########################################
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            memOut <= '0;                        // Cleared bundle is a bubble
        end else if (wrEn) begin
            memOut.aluOut     <= exeIn.aluOut;
            memOut.storeData  <= exeIn.storeData;
            memOut.pc         <= exeIn.pc;
            memOut.instr      <= exeIn.instr;
            memOut.isBranch   <= exeIn.isBranch;   // Single branch bit only
            memOut.isImmeJump <= exeIn.isImmeJump;
            memOut.loadType   <= exeIn.loadType;
            memOut.storeType  <= exeIn.storeType;
            memOut.dst        <= exeIn.dst;
            memOut.regsWr     <= exeIn.regsWr;
            memOut.wbSel      <= exeIn.wbSel;
            memOut.except     <= exeIn.except;
            memOut.hi         <= exeIn.hi;
            memOut.lo         <= exeIn.lo;
            memOut.valid      <= exeIn.valid;
        end
    end

    // ########################################
    // Checks
    // ########################################

    // A flushed instruction never reaches the memory controller
    flushKillsValid: assert property (
        @(posedge clk) disable iff (!rstN)
        flush |=> !memOut.valid
    );

endmodule

// File: storeAligner.sv
`timescale 1ns/1ps

module storeAligner import cpuPkg::*; (
    input  storeType_t  storeType,
    input  logic [31:0] addr,
    input  logic [31:0] storeData,
    output logic [3:0]  byteEn,
    output logic [31:0] wData,
    output logic        adES
);

    logic [3:0] laneEn;                          // Enables before error masking

    always_comb begin
        laneEn = 4'b0000;
        wData  = storeData;
        adES   = 1'b0;
        case (storeType)
            ST_SB: begin
                laneEn = 4'b0001 << addr[1:0];
                wData  = {4{storeData[7:0]}};    // Byte on every lane
            end
            ST_SH: begin
                laneEn = addr[1] ? 4'b1100 : 4'b0011;
                wData  = {2{storeData[15:0]}};   // Half on both halves
                adES   = addr[0];
            end
            ST_SW: begin
                laneEn = 4'b1111;
                adES   = |addr[1:0];
            end
            default: begin
                laneEn = 4'b0000;                // No store
            end
        endcase
    end

    // Misaligned store touches no lane
    assign byteEn = adES ? 4'b0000 : laneEn;

endmodule

// File: loadAligner.sv
`timescale 1ns/1ps

module loadAligner import cpuPkg::*; (
    input  loadType_t   loadType,
    input  logic [31:0] addr,
    input  dataWord_u   rData,
    output logic [31:0] loadData,
    output logic        adEL
);

    logic [7:0]  selByte;
    logic [15:0] selHalf;

    // Lane picks straight off the union views
    assign selByte = rData.bytes[addr[1:0]];
    assign selHalf = rData.halves[addr[1]];

    always_comb begin
        loadData = rData;
        adEL     = 1'b0;
        case (loadType)
            LD_LB: begin
                loadData = {{24{selByte[7]}}, selByte};
            end
            LD_LBU: begin
                loadData = {24'h000000, selByte};
            end
            LD_LH: begin
                loadData = {{16{selHalf[15]}}, selHalf};
                adEL     = addr[0];
            end
            LD_LHU: begin
                loadData = {16'h0000, selHalf};
                adEL     = addr[0];
            end
            LD_LW: begin
                loadData = rData;                // Whole word as read
                adEL     = |addr[1:0];
            end
            default: begin
                loadData = rData;                // Not a load, result ignored
            end
        endcase
    end

endmodule

// File: memAccessCtrl.sv
`timescale 1ns/1ps

module memAccessCtrl import cpuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       flush,
    input  logic       valid,
    input  loadType_t  loadType,
    input  storeType_t storeType,
    input  logic       addrErr,                  // adEL or adES of this instruction
    input  logic       dmemValid,
    input  logic       timeout,
    output logic       dmemReq,
    output logic       stall,
    output logic       timerRun,
    output logic       wbValid,
    output logic       busErr
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_t;

    state_t state;
    logic   isMem;
    logic   start;
    logic   done;

    // ########################################
    // Access decode
    // ########################################
    assign isMem = (loadType != LD_NONE) || (storeType != ST_NONE);
    assign start = (state == IDLE) && valid && isMem && !addrErr && !flush;
    assign done  = (state == WAIT) && (dmemValid || timeout) && !flush;

    // ########################################
    // State register
    // ########################################
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            state <= IDLE;                       // Abandon any access in flight
        end else if (start) begin
            state <= WAIT;
        end else if (done) begin
            state <= IDLE;                       // Next instruction loads this edge
        end
    end

    assign dmemReq  = start;
    assign stall    = start || ((state == WAIT) && !done && !flush);
    assign timerRun = (state == WAIT);
    assign busErr   = done && !dmemValid;        // Data wins over a late timeout
    assign wbValid  = done ||
                      ((state == IDLE) && valid && !flush && (!isMem || addrErr));

    // ########################################
    // Checks
    // ########################################
    singleReqPulse: assert property (
        @(posedge clk) disable iff (!rstN)
        dmemReq |=> !dmemReq
    );

    noWbWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN)
        !(wbValid && stall)
    );

endmodule

// File: accessTimer.sv
`timescale 1ns/1ps

module accessTimer import cpuPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic run,                            // High while an access waits
    output logic timeout
);

    logic [TIMER_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign timeout = run && (count == TIMER_WIDTH'(MEM_TIMEOUT));

    // Timeout only after an unbroken wait of MEM_TIMEOUT cycles
    timeoutAfterWait: assert property (
        @(posedge clk) disable iff (!rstN)
        timeout |-> run && $past(run, MEM_TIMEOUT)
    );

endmodule

// File: memStage.sv
`timescale 1ns/1ps

module memStage import cpuPkg::*; (
    input  logic          clk,
    input  logic          rstN,
    input  logic          flush,
    input  exeMemBundle_t exeIn,
    output logic          stall,
    output memWbBundle_t  wbOut,
    output logic          wbValid,
    output logic          dmemReq,
    output logic          dmemWe,
    output logic [31:0]   dmemAddr,
    output logic [3:0]    dmemByteEn,
    output logic [31:0]   dmemWData,
    input  dataWord_u     dmemRData,
    input  logic          dmemValid
);

    exeMemBundle_t memQ;
    logic [31:0]   loadData;
    logic          adEL;
    logic          adES;
    logic          busErr;
    logic          timeout;
    logic          timerRun;

    // ########################################
    // Datapath
    // ########################################
    memStageReg uReg (
        .clk    (clk),
        .rstN   (rstN),
        .flush  (flush),
        .wrEn   (!stall),
        .exeIn  (exeIn),
        .memOut (memQ)
    );

    storeAligner uStore (
        .storeType (memQ.storeType),
        .addr      (memQ.aluOut),
        .storeData (memQ.storeData),
        .byteEn    (dmemByteEn),
        .wData     (dmemWData),
        .adES      (adES)
    );

    loadAligner uLoad (
        .loadType (memQ.loadType),
        .addr     (memQ.aluOut),
        .rData    (dmemRData),
        .loadData (loadData),
        .adEL     (adEL)
    );

    // ########################################
    // Control
    // ########################################
    memAccessCtrl uCtrl (
        .clk       (clk),
        .rstN      (rstN),
        .flush     (flush),
        .valid     (memQ.valid),
        .loadType  (memQ.loadType),
        .storeType (memQ.storeType),
        .addrErr   (adEL || adES),
        .dmemValid (dmemValid),
        .timeout   (timeout),
        .dmemReq   (dmemReq),
        .stall     (stall),
        .timerRun  (timerRun),
        .wbValid   (wbValid),
        .busErr    (busErr)
    );

    accessTimer uTimer (
        .clk     (clk),
        .rstN    (rstN),
        .run     (timerRun),
        .timeout (timeout)
    );

    assign dmemWe   = (memQ.storeType != ST_NONE);
    assign dmemAddr = memQ.aluOut;

    // Write-back bundle
    assign wbOut.result = (memQ.loadType != LD_NONE) ? loadData : memQ.aluOut;
    assign wbOut.pc     = memQ.pc;
    assign wbOut.instr  = memQ.instr;
    assign wbOut.dst    = memQ.dst;
    assign wbOut.regsWr = memQ.regsWr;
    assign wbOut.wbSel  = memQ.wbSel;
    assign wbOut.hi     = memQ.hi;
    assign wbOut.lo     = memQ.lo;
    assign wbOut.except = '{upstream: memQ.except.upstream,
                            adEL:     adEL,
                            adES:     adES,
                            busErr:   busErr};

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                   // 8 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);               // Reset held 4 cycles
        rstN <= 1'b1;
    end

endmodule

// File: tbChecker.sv
`timescale 1ns/1ps

module tbChecker import cpuPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              flush,
    input  exeMemBundle_t     exeIn,
    input  logic              stall,
    input  memWbBundle_t      wbOut,
    input  logic              wbValid,
    input  logic              dmemReq,
    input  logic              dmemWe,
    input  logic [31:0]       dmemAddr,
    input  logic [3:0]        dmemByteEn,
    input  logic [31:0]       dmemWData,
    input  logic              dmemValid,
    input  logic [15:0][31:0] memInit,
    output int                errCount,
    output int                wbCount
);

    exeMemBundle_t     cur;                      // Mirror of the EXE/MEM register
    logic [15:0][31:0] shadow;
    logic              reqSeen;
    int                waitCnt;
    int                errs = 0;
    int                wbs = 0;

    assign errCount = errs;
    assign wbCount  = wbs;

    // ########################################
    // Reference rules
    // ########################################
    function automatic logic isMisaligned(loadType_t ld, storeType_t st, logic [31:0] a);
        if (ld == LD_LH || ld == LD_LHU || st == ST_SH) return a[0];
        if (ld == LD_LW || st == ST_SW) return |a[1:0];
        return 1'b0;
    endfunction

    function automatic logic [3:0] expByteEn(storeType_t st, logic [31:0] a);
        if (isMisaligned(LD_NONE, st, a)) return 4'b0000;
        case (st)
            ST_SB:   return 4'b0001 << a[1:0];
            ST_SH:   return a[1] ? 4'b1100 : 4'b0011;
            ST_SW:   return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic logic [31:0] expWData(storeType_t st, logic [31:0] d);
        case (st)
            ST_SB:   return {4{d[7:0]}};
            ST_SH:   return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic logic [31:0] expLoad(loadType_t ld, logic [31:0] a, logic [31:0] w);
        logic [31:0] byteSh;
        logic [31:0] halfSh;
        byteSh = w >> (8 * a[1:0]);
        halfSh = w >> (16 * a[1]);
        case (ld)
            LD_LB:   return {{24{byteSh[7]}}, byteSh[7:0]};
            LD_LBU:  return {24'h0, byteSh[7:0]};
            LD_LH:   return {{16{halfSh[15]}}, halfSh[15:0]};
            LD_LHU:  return {16'h0, halfSh[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic compareValue(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic reportProblem(string what);
        $display("%s at %0t", what, $time);
        errs++;
    endtask

    // Merge the enabled store lanes into the shadow word
    task automatic storeToShadow();
        logic [3:0]  en;
        logic [31:0] wd;
        en = expByteEn(cur.storeType, cur.aluOut);
        wd = expWData(cur.storeType, cur.storeData);
        for (int l = 0; l < 4; l++) begin
            if (en[l]) shadow[cur.aluOut[5:2]][8*l +: 8] = wd[8*l +: 8];
        end
    endtask

    // ########################################
    // Write-back check
    // ########################################
    task automatic checkWriteBack();
        exceptType_t expExc;
        logic        mis;
        logic        isMem;
        mis   = isMisaligned(cur.loadType, cur.storeType, cur.aluOut);
        isMem = (cur.loadType != LD_NONE) || (cur.storeType != ST_NONE);
        wbs++;
        if (!cur.valid) reportProblem("write-back without a valid instruction");
        if (isMem && !mis && !reqSeen) reportProblem("memory access completed without request");
        if ((!isMem || mis) && reqSeen) reportProblem("request raised for an access that needs none");
        expExc.upstream = cur.except.upstream;
        expExc.adEL     = (cur.loadType != LD_NONE) && mis;
        expExc.adES     = (cur.storeType != ST_NONE) && mis;
        expExc.busErr   = reqSeen && !dmemValid;
        if (expExc.busErr && waitCnt < MEM_TIMEOUT) reportProblem("bus error came too early");
        if (cur.loadType == LD_NONE) begin
            compareValue("wbOut.result", cur.aluOut, wbOut.result);
        end else if (!mis && !expExc.busErr) begin
            compareValue("wbOut.result",
                         expLoad(cur.loadType, cur.aluOut, shadow[cur.aluOut[5:2]]),
                         wbOut.result);
        end
        compareValue("stall", 32'h0, 32'(stall));   // Released in the last cycle
        compareValue("wbOut.pc", cur.pc, wbOut.pc);
        compareValue("wbOut.instr", cur.instr, wbOut.instr);
        compareValue("wbOut.dst", 32'(cur.dst), 32'(wbOut.dst));
        compareValue("wbOut.regsWr", 32'(cur.regsWr), 32'(wbOut.regsWr));
        compareValue("wbOut.wbSel", 32'(cur.wbSel), 32'(wbOut.wbSel));
        compareValue("wbOut.hi", cur.hi, wbOut.hi);
        compareValue("wbOut.lo", cur.lo, wbOut.lo);
        compareValue("wbOut.except", 32'(expExc), 32'(wbOut.except));
        reqSeen = 1'b0;
    endtask

    // ########################################
    // Port monitor
    // ########################################
    always @(posedge clk) begin
        if (!rstN) begin
            cur     = '0;
            reqSeen = 1'b0;
            waitCnt = 0;
            shadow  = memInit;                   // Same contents as the model
        end else begin
            if (dmemReq) begin
                if (!cur.valid || isMisaligned(cur.loadType, cur.storeType, cur.aluOut) ||
                    (cur.loadType == LD_NONE && cur.storeType == ST_NONE))
                    reportProblem("memory request without a legal access");
                if (reqSeen) reportProblem("second request for one instruction");
                compareValue("dmemAddr", cur.aluOut, dmemAddr);
                compareValue("dmemWe", 32'(cur.storeType != ST_NONE), 32'(dmemWe));
                compareValue("dmemByteEn", 32'(expByteEn(cur.storeType, cur.aluOut)),
                             32'(dmemByteEn));
                if (cur.storeType != ST_NONE) begin
                    compareValue("dmemWData", expWData(cur.storeType, cur.storeData),
                                 dmemWData);
                    storeToShadow();
                end
                compareValue("stall", 32'h1, 32'(stall));
                reqSeen = 1'b1;
                waitCnt = 0;
            end else if (reqSeen && !wbValid && !flush) begin
                waitCnt++;
                compareValue("stall", 32'h1, 32'(stall));   // Still waiting
            end
            if (wbValid) checkWriteBack();
            if (flush) begin
                cur     = '0;
                reqSeen = 1'b0;
            end else if (!stall) begin
                cur = exeIn;
            end
        end
    end

endmodule

// File: tbMemStage.sv
`timescale 1ns/1ps

module tbMemStage import cpuPkg::*; ();

    typedef struct {
        loadType_t   ld;
        storeType_t  st;
        logic [31:0] addr;
        logic [31:0] data;
        int          lat;                        // 31 means no answer
        int          flushAfter;                 // 0 means no flush
    } row_t;

    logic              clk;
    logic              rstN;
    logic              flush = 1'b0;
    exeMemBundle_t     exeIn = '0;
    logic              stall;
    memWbBundle_t      wbOut;
    logic              wbValid;
    logic              dmemReq;
    logic              dmemWe;
    logic [31:0]       dmemAddr;
    logic [3:0]        dmemByteEn;
    logic [31:0]       dmemWData;
    dataWord_u         dmemRData = '0;
    logic              dmemValid = 1'b0;
    logic [15:0][31:0] memInit;
    logic [15:0][31:0] mem;
    row_t              rows[$];
    int                errCount;
    int                wbCount;
    int                timeoutErrs = 0;
    int                expWb = 0;
    int                pendCnt = 0;
    logic              pending = 1'b0;

    tbClock uClock (.clk(clk), .rstN(rstN));

    memStage DUT (.*);

    tbChecker uChecker (.*);

    // Galois LFSR, one step per bit
    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // ########################################
    // Memory model
    // ########################################
    always @(posedge clk) begin
        dmemValid <= 1'b0;
        if (!rstN) begin
            mem     <= memInit;
            pending <= 1'b0;
        end else if (dmemReq) begin
            for (int l = 0; l < 4; l++) begin
                if (dmemWe && dmemByteEn[l]) mem[dmemAddr[5:2]][8*l +: 8] <= dmemWData[8*l +: 8];
            end
            dmemRData <= mem[dmemAddr[5:2]];
            if (rows[0].lat == 0) dmemValid <= 1'b1;   // Answer in the first wait cycle
            pending <= (rows[0].lat != 0) && (rows[0].lat != 31);
            pendCnt <= rows[0].lat;
        end else if (pending) begin
            if (pendCnt == 1) begin
                dmemValid <= 1'b1;
                pending   <= 1'b0;
            end
            pendCnt <= pendCnt - 1;
        end
    end

    // ########################################
    // Stimulus table
    // ########################################
    task automatic addRow(loadType_t ld, storeType_t st, logic [31:0] a, logic [31:0] d,
                          int lat, int fl);
        rows.push_back('{ld, st, a, d, lat, fl});
        if (fl == 0) expWb++;
    endtask

    function automatic exeMemBundle_t makeBundle(int i, row_t r);
        exeMemBundle_t b;
        b                 = '0;
        b.aluOut          = r.addr;
        b.storeData       = r.data;
        b.pc              = 32'h400 + 4 * i;
        b.instr           = 32'(i);
        b.loadType        = r.ld;
        b.storeType       = r.st;
        b.dst             = 5'(i);
        b.regsWr          = i[0];
        b.wbSel           = 2'(i >> 1);
        b.except.upstream = 8'(i);
        b.hi              = ~b.pc;
        b.lo              = b.pc ^ r.data;
        b.valid           = 1'b1;
        return b;
    endfunction

    task automatic runRow(int i, row_t r);
        logic got;
        got = 1'b0;
        exeIn <= makeBundle(i, r);
        @(posedge clk);                          // Register captures here
        exeIn <= '0;
        if (r.flushAfter > 0) begin
            repeat (r.flushAfter) begin
                @(posedge clk);
                if (wbValid) begin
                    $display("row %0d completed before its flush", i);
                    timeoutErrs++;
                end
            end
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            for (int k = 0; k < 64 && !got; k++) begin
                @(posedge clk);
                got = dmemValid;                 // Late answer for the dead access
            end
        end else begin
            for (int k = 0; k < 64 && !got; k++) begin
                @(posedge clk);
                got = wbValid;
            end
        end
        if (!got) begin
            $display("row %0d timed out waiting for the memory stage", i);
            timeoutErrs++;
        end
    endtask

    initial begin
        logic [15:0] lfsr;
        int          n;
        lfsr = 16'd1392;
        for (int w = 0; w < 16; w++) begin
            for (int b = 0; b < 32; b++) begin
                memInit[w][b] = lfsr[0];
                lfsr = lfsrStep(lfsr);
            end
        end
        addRow(LD_NONE, ST_NONE, 32'h1234_5678, 32'h0, 0, 0);
        for (int o = 0; o < 4; o++) addRow(LD_NONE, ST_SB, 32'h04 + o, 32'hA0 + o, 2, 0);
        addRow(LD_LW, ST_NONE, 32'h04, 32'h0, 1, 0);
        addRow(LD_NONE, ST_SH, 32'h08, 32'h1111_BEEF, 0, 0);
        addRow(LD_NONE, ST_SH, 32'h0A, 32'h2222_CAFE, 3, 0);
        addRow(LD_LW, ST_NONE, 32'h08, 32'h0, 0, 0);
        addRow(LD_NONE, ST_SW, 32'h0C, 32'hDEAD_F00D, 10, 0);
        addRow(LD_LW, ST_NONE, 32'h0C, 32'h0, 3, 0);
        n = 0;
        for (int o = 0; o < 4; o++) begin
            addRow(LD_LB, ST_NONE, 32'h10 + o, 32'h0, (n % 3 == 0) ? 0 : (n % 3 == 1) ? 3 : 10, 0);
            n++;
            addRow(LD_LBU, ST_NONE, 32'h14 + o, 32'h0, (n % 3 == 0) ? 0 : (n % 3 == 1) ? 3 : 10, 0);
            n++;
        end
        for (int o = 0; o < 3; o++) begin
            addRow(LD_LH, ST_NONE, 32'h18 + 2 * (o % 2), 32'h0, (o == 0) ? 0 : (o == 1) ? 3 : 10, 0);
            addRow(LD_LHU, ST_NONE, 32'h1A - 2 * (o % 2), 32'h0, (o == 0) ? 10 : (o == 1) ? 0 : 3, 0);
            addRow(LD_LW, ST_NONE, 32'h1C, 32'h0, (o == 0) ? 3 : (o == 1) ? 10 : 0, 0);
        end
        addRow(LD_LH, ST_NONE, 32'h21, 32'h0, 0, 0);   // Misaligned accesses
        addRow(LD_LW, ST_NONE, 32'h22, 32'h0, 0, 0);
        addRow(LD_NONE, ST_SH, 32'h23, 32'h5555, 0, 0);
        addRow(LD_NONE, ST_SW, 32'h25, 32'h6666, 0, 0);
        addRow(LD_LW, ST_NONE, 32'h20, 32'h0, 31, 0);  // Silent memory
        addRow(LD_LW, ST_NONE, 32'h20, 32'h0, 1, 0);
        addRow(LD_LW, ST_NONE, 32'h24, 32'h0, 10, 3);  // Flushed while waiting
        addRow(LD_LBU, ST_NONE, 32'h25, 32'h0, 0, 0);

        for (int k = 0; k < 20 && !rstN; k++) @(posedge clk);
        if (!rstN) begin
            $display("reset never released");
            timeoutErrs++;
        end
        n = 0;
        while (rows.size() > 0) begin
            runRow(n, rows[0]);
            void'(rows.pop_front());
            n++;
        end
        repeat (3) @(posedge clk);
        if (wbCount != expWb) $display("saw %0d write-backs where %0d were due", wbCount, expWb);
        $display("check errors %0d, timeouts %0d, write-backs %0d of %0d",
                 errCount, timeoutErrs, wbCount, expWb);
        if (errCount == 0 && timeoutErrs == 0 && wbCount == expWb) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
cpuPkg.sv
memStageReg.sv
storeAligner.sv
loadAligner.sv
memAccessCtrl.sv
accessTimer.sv
memStage.sv
tbClock.sv
tbChecker.sv
tbMemStage.sv
